// File: logic/frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// First fetch address after reset
`define RESET_PC 32'h1c00_0000

// Instruction buffer entries, power of two
`define IB_DEPTH 16

// Hold fetch while free entries drop below this
// Covers the pair in predecode and the pair at the cache
`define IB_FILL_LIMIT 4

// Bits 31..26 of a direct conditional branch
`define BR_OPCODE 6'b010110

`endif

// File: logic/frontend_pkg.sv
package frontend_pkg;

    // Byte address and raw instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // Backend pipeline control
    typedef struct packed {
        logic stall_if;
        logic stall_id;
        logic excp_flush;
    } ctrl_t;

    // Exception redirect target
    typedef addr_t ctrl_pc_t;

    // Fetch pair address, second word always first + 4
    typedef struct packed {
        addr_t pc_o_1;
        addr_t pc_o_2;
    } pc_out;

    // One predecoded pair
    typedef struct packed {
        logic  valid_1;
        logic  valid_2;
        addr_t pc_1;
        addr_t pc_2;
        inst_t inst_1;
        inst_t inst_2;
    } inst_and_pc_t;

    // Static prediction facts for one slot
    typedef struct packed {
        logic  is_branch;
        logic  pre_taken;
        addr_t pre_target;
    } branch_info;

endpackage

// File: logic/pc_reg.sv
`include "frontend_macros.svh"

module pc_reg
    import frontend_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,

    // Backend control
    input  ctrl_t    ctrl_i,
    input  ctrl_pc_t ctrl_pc_i,
    input  logic     branch_flush_i,
    input  addr_t    branch_actual_addr_i,

    // Static prediction redirect from bpu
    input  logic     pre_taken_or_not_i,
    input  addr_t    pre_branch_addr_i,

    // Buffer near full
    input  logic     ib_hold_i,

    // Cache request
    output pc_out    pc_o,
    output logic     inst_en_1_o,
    output logic     inst_en_2_o
);

    addr_t pc_q;
    addr_t pc_next;
    logic  run_q;
    logic  fetching;

    // Fetch starts one edge after reset is released
    assign fetching = run_q & ~ctrl_i.stall_if & ~ib_hold_i;

    ////////////////////////////////////////////////////////////////////
    // Next pair address, highest priority first
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        if (ctrl_i.excp_flush) begin
            pc_next = ctrl_pc_i;
        end else if (branch_flush_i) begin
            pc_next = branch_actual_addr_i;
        end else if (pre_taken_or_not_i) begin
            pc_next = pre_branch_addr_i;
        end else if (fetching) begin
            // Two words per cycle
            pc_next = pc_q + 32'd8;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q  <= `RESET_PC;
            run_q <= 1'b0;
        end else begin
            pc_q  <= pc_next;
            run_q <= 1'b1;
        end
    end

    assign pc_o.pc_o_1 = pc_q;
    assign pc_o.pc_o_2 = pc_q + 32'd4;

    // Both slots are always requested together
    assign inst_en_1_o = fetching;
    assign inst_en_2_o = fetching;

endmodule

// File: logic/bpu.sv
`include "frontend_macros.svh"

module bpu
    import frontend_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n_i,
    input  logic         branch_flush_i,
    input  logic         excp_flush_i,

    // Request as issued to the cache this cycle
    input  pc_out        pc_i,
    input  logic         inst_en_1_i,
    input  logic         inst_en_2_i,

    // Cache data for last cycle's request
    input  inst_t        inst_1_i,
    input  inst_t        inst_2_i,

    // Redirect toward pc_reg, same cycle
    output logic         pre_taken_or_not_o,
    output addr_t        pre_branch_addr_o,

    // Registered pair toward the buffer
    output inst_and_pc_t inst_and_pc_o,
    output branch_info   branch_info1_o,
    output branch_info   branch_info2_o,
    output logic         fetch_inst_1_en_o,
    output logic         fetch_inst_2_en_o
);

    logic       flush;

    // In-flight request
    pc_out      req_pc_q;
    logic       req_en_1_q;
    logic       req_en_2_q;
    logic       kill_q;

    // Predecode
    branch_info info_1;
    branch_info info_2;
    logic       live_1;
    logic       live_2;
    logic       take_1;
    logic       keep_2;
    logic       take_2;

    // Output stage
    logic       out_v1_q;
    logic       out_v2_q;
    addr_t      out_pc1_q;
    addr_t      out_pc2_q;
    inst_t      out_inst1_q;
    inst_t      out_inst2_q;
    branch_info out_info1_q;
    branch_info out_info2_q;

    // Opcode match, target is pc + 4 * sext(imm16), backward means taken
    function automatic branch_info predecode(input addr_t pc, input inst_t inst);
        branch_info bi;
        addr_t      offset;
        offset        = {{14{inst[15]}}, inst[15:0], 2'b00};
        bi.is_branch  = (inst[31:26] == `BR_OPCODE);
        bi.pre_taken  = bi.is_branch & inst[15];
        bi.pre_target = bi.is_branch ? pc + offset : '0;
        return bi;
    endfunction

    assign flush = branch_flush_i | excp_flush_i;

    ////////////////////////////////////////////////////////////////////
    // Request capture, lines up with the cache data one cycle later
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_en_1_q <= 1'b0;
            req_en_2_q <= 1'b0;
            kill_q     <= 1'b0;
        end else if (flush) begin
            req_en_1_q <= 1'b0;
            req_en_2_q <= 1'b0;
            kill_q     <= 1'b0;
        end else begin
            req_en_1_q <= inst_en_1_i;
            req_en_2_q <= inst_en_2_i;
            // Pair issued alongside a redirect is wrong-path
            kill_q     <= pre_taken_or_not_o;
        end
    end

    always_ff @(posedge clk) begin
        req_pc_q <= pc_i;
    end

    ////////////////////////////////////////////////////////////////////
    // Static prediction
    ////////////////////////////////////////////////////////////////////
    assign info_1 = predecode(req_pc_q.pc_o_1, inst_1_i);
    assign info_2 = predecode(req_pc_q.pc_o_2, inst_2_i);

    assign live_1 = req_en_1_q & ~kill_q;
    assign live_2 = req_en_2_q & ~kill_q;

    // Taken slot 1 discards slot 2
    assign take_1 = live_1 & info_1.pre_taken;
    assign keep_2 = live_2 & ~take_1;
    assign take_2 = keep_2 & info_2.pre_taken;

    assign pre_taken_or_not_o = take_1 | take_2;
    assign pre_branch_addr_o  = take_1 ? info_1.pre_target : info_2.pre_target;

    // Surviving slots toward the buffer
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_v1_q <= 1'b0;
            out_v2_q <= 1'b0;
        end else if (flush) begin
            out_v1_q <= 1'b0;
            out_v2_q <= 1'b0;
        end else begin
            out_v1_q <= live_1;
            out_v2_q <= keep_2;
        end
    end

    always_ff @(posedge clk) begin
        out_pc1_q   <= req_pc_q.pc_o_1;
        out_pc2_q   <= req_pc_q.pc_o_2;
        out_inst1_q <= inst_1_i;
        out_inst2_q <= inst_2_i;
        out_info1_q <= info_1;
        out_info2_q <= info_2;
    end

    always_comb begin
        inst_and_pc_o.valid_1 = out_v1_q;
        inst_and_pc_o.valid_2 = out_v2_q;
        inst_and_pc_o.pc_1    = out_pc1_q;
        inst_and_pc_o.pc_2    = out_pc2_q;
        inst_and_pc_o.inst_1  = out_inst1_q;
        inst_and_pc_o.inst_2  = out_inst2_q;
    end

    assign branch_info1_o    = out_info1_q;
    assign branch_info2_o    = out_info2_q;
    assign fetch_inst_1_en_o = out_v1_q;
    assign fetch_inst_2_en_o = out_v2_q;

endmodule

// File: logic/instbuffer.sv
`include "frontend_macros.svh"

module instbuffer
    import frontend_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n_i,
    input  logic         flush_i,
    input  logic         stall_id_i,

    // Write side from bpu
    input  inst_and_pc_t inst_and_pc_i,
    input  branch_info   branch_info1_i,
    input  branch_info   branch_info2_i,
    input  logic         fetch_inst_1_en_i,
    input  logic         fetch_inst_2_en_i,

    // Read side toward issue
    input  logic         send_inst_1_en_i,
    input  logic         send_inst_2_en_i,
    output inst_and_pc_t inst_and_pc_o,
    output branch_info   branch_info1_o,
    output branch_info   branch_info2_o,

    output logic         ib_hold_o
);

    localparam int DEPTH = `IB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    typedef struct packed {
        addr_t      pc;
        inst_t      inst;
        branch_info info;
    } ib_entry_t;

    ib_entry_t mem [DEPTH];

    ptr_t      rd_ptr_q;
    ptr_t      wr_ptr_q;
    cnt_t      count_q;

    ptr_t      wr_ptr_2;
    ptr_t      rd_ptr_2;
    ib_entry_t new_1;
    ib_entry_t new_2;
    ib_entry_t head_1;
    ib_entry_t head_2;
    logic      vld_1;
    logic      vld_2;
    logic      take_1;
    logic      take_2;
    cnt_t      n_wr;
    cnt_t      n_rd;
    cnt_t      free_cnt;

    ////////////////////////////////////////////////////////////////////
    // Write side, compacted
    ////////////////////////////////////////////////////////////////////
    assign new_1 = '{pc: inst_and_pc_i.pc_1, inst: inst_and_pc_i.inst_1, info: branch_info1_i};
    assign new_2 = '{pc: inst_and_pc_i.pc_2, inst: inst_and_pc_i.inst_2, info: branch_info2_i};

    // Lone slot 2 lands on the next free entry
    assign wr_ptr_2 = wr_ptr_q + ptr_t'(fetch_inst_1_en_i);
    assign n_wr     = cnt_t'(fetch_inst_1_en_i) + cnt_t'(fetch_inst_2_en_i);

    always_ff @(posedge clk) begin
        if (fetch_inst_1_en_i) begin
            mem[wr_ptr_q] <= new_1;
        end
        if (fetch_inst_2_en_i) begin
            mem[wr_ptr_2] <= new_2;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read side, two oldest entries
    ////////////////////////////////////////////////////////////////////
    assign rd_ptr_2 = rd_ptr_q + ptr_t'(1);
    assign head_1   = mem[rd_ptr_q];
    assign head_2   = mem[rd_ptr_2];

    assign vld_1 = (count_q != '0);
    assign vld_2 = (count_q > cnt_t'(1));

    // send_inst_2_en_i alone takes nothing
    assign take_1 = send_inst_1_en_i & vld_1 & ~stall_id_i;
    assign take_2 = take_1 & send_inst_2_en_i & vld_2;
    assign n_rd   = cnt_t'(take_1) + cnt_t'(take_2);

    always_comb begin
        inst_and_pc_o.valid_1 = vld_1;
        inst_and_pc_o.valid_2 = vld_2;
        inst_and_pc_o.pc_1    = head_1.pc;
        inst_and_pc_o.pc_2    = head_2.pc;
        inst_and_pc_o.inst_1  = head_1.inst;
        inst_and_pc_o.inst_2  = head_2.inst;
    end

    assign branch_info1_o = head_1.info;
    assign branch_info2_o = head_2.info;

    // Pointers and occupancy
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + ptr_t'(n_rd);
            wr_ptr_q <= wr_ptr_q + ptr_t'(n_wr);
            count_q  <= count_q + n_wr - n_rd;
        end
    end

    // Pending write counted as taken, reads ignored
    assign free_cnt  = cnt_t'(DEPTH) - count_q;
    assign ib_hold_o = (free_cnt < n_wr + cnt_t'(`IB_FILL_LIMIT));

endmodule

// File: logic/frontend_top.sv
module frontend_top
    import frontend_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n_i,
    input  ctrl_t        ctrl_i,
    input  ctrl_pc_t     ctrl_pc_i,
    input  logic         branch_flush_i,
    input  addr_t        branch_actual_addr_i,

    // Instruction cache
    input  inst_t        inst_1_i,
    input  inst_t        inst_2_i,
    output logic         inst_en_1_o,
    output logic         inst_en_2_o,
    output addr_t        pc1_o,
    output addr_t        pc2_o,

    // Issue handshake
    input  logic         send_inst_1_en_i,
    input  logic         send_inst_2_en_i,
    output branch_info   branch_info1_o,
    output branch_info   branch_info2_o,
    output inst_and_pc_t inst_and_pc_o
);

    pc_out        pc;
    logic         pre_taken_or_not;
    addr_t        pre_branch_addr;
    logic         ib_hold;
    logic         any_flush;

    // bpu to buffer
    inst_and_pc_t bpu_pair;
    branch_info   bpu_info1;
    branch_info   bpu_info2;
    logic         fetch_inst_1_en;
    logic         fetch_inst_2_en;

    assign any_flush = branch_flush_i | ctrl_i.excp_flush;

    assign pc1_o = pc.pc_o_1;
    assign pc2_o = pc.pc_o_2;

    pc_reg u_pc_reg (
        .clk                  (clk),
        .arst_n_i             (arst_n_i),
        .ctrl_i               (ctrl_i),
        .ctrl_pc_i            (ctrl_pc_i),
        .branch_flush_i       (branch_flush_i),
        .branch_actual_addr_i (branch_actual_addr_i),
        .pre_taken_or_not_i   (pre_taken_or_not),
        .pre_branch_addr_i    (pre_branch_addr),
        .ib_hold_i            (ib_hold),
        .pc_o                 (pc),
        .inst_en_1_o          (inst_en_1_o),
        .inst_en_2_o          (inst_en_2_o)
    );

    bpu u_bpu (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .branch_flush_i     (branch_flush_i),
        .excp_flush_i       (ctrl_i.excp_flush),
        .pc_i               (pc),
        .inst_en_1_i        (inst_en_1_o),
        .inst_en_2_i        (inst_en_2_o),
        .inst_1_i           (inst_1_i),
        .inst_2_i           (inst_2_i),
        .pre_taken_or_not_o (pre_taken_or_not),
        .pre_branch_addr_o  (pre_branch_addr),
        .inst_and_pc_o      (bpu_pair),
        .branch_info1_o     (bpu_info1),
        .branch_info2_o     (bpu_info2),
        .fetch_inst_1_en_o  (fetch_inst_1_en),
        .fetch_inst_2_en_o  (fetch_inst_2_en)
    );

    instbuffer u_instbuffer (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .flush_i           (any_flush),
        .stall_id_i        (ctrl_i.stall_id),
        .inst_and_pc_i     (bpu_pair),
        .branch_info1_i    (bpu_info1),
        .branch_info2_i    (bpu_info2),
        .fetch_inst_1_en_i (fetch_inst_1_en),
        .fetch_inst_2_en_i (fetch_inst_2_en),
        .send_inst_1_en_i  (send_inst_1_en_i),
        .send_inst_2_en_i  (send_inst_2_en_i),
        .inst_and_pc_o     (inst_and_pc_o),
        .branch_info1_o    (branch_info1_o),
        .branch_info2_o    (branch_info2_o),
        .ib_hold_o         (ib_hold)
    );

endmodule

// File: tests/frontend_assert.sv
`include "frontend_macros.svh"

module frontend_assert
    import frontend_pkg::*;
(
    input logic         clk,
    input logic         arst_n_i,
    input ctrl_t        ctrl_i,
    input ctrl_pc_t     ctrl_pc_i,
    input logic         branch_flush_i,
    input addr_t        branch_actual_addr_i,
    input logic         inst_en_1_o,
    input logic         inst_en_2_o,
    input addr_t        pc1_o,
    input inst_and_pc_t inst_and_pc_o
);

    // Number of failed assertions
    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////////////
    // Reset behavior
    ////////////////////////////////////////////////////////////////////
    // Checked from the second reset cycle on
    a_reset_idle: assert property (@(posedge clk)
        !arst_n_i && $past(!arst_n_i) |-> !inst_en_1_o && !inst_en_2_o
                      && !inst_and_pc_o.valid_1 && !inst_and_pc_o.valid_2
                      && pc1_o == `RESET_PC)
        else begin
            $error("outputs not idle during reset");
            fail_cnt = fail_cnt + 1;
        end

    a_first_cycle: assert property (@(posedge clk)
        arst_n_i && !$past(arst_n_i) |-> !inst_en_1_o)
        else begin
            $error("enables high on the release edge");
            fail_cnt = fail_cnt + 1;
        end

    a_fetch_start: assert property (@(posedge clk)
        $past(arst_n_i) && !$past(arst_n_i, 2) && !ctrl_i.stall_if |-> inst_en_1_o)
        else begin
            $error("fetch did not start after reset");
            fail_cnt = fail_cnt + 1;
        end

    ////////////////////////////////////////////////////////////////////
    // Fetch stall
    ////////////////////////////////////////////////////////////////////
    a_stall_en: assert property (@(posedge clk) disable iff (!arst_n_i)
        ctrl_i.stall_if |-> !inst_en_1_o)
        else begin
            $error("enables high under stall_if");
            fail_cnt = fail_cnt + 1;
        end

    a_stall_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        ctrl_i.stall_if && $past(ctrl_i.stall_if) && $past(ctrl_i.stall_if, 2)
        && !$past(branch_flush_i) && !$past(ctrl_i.excp_flush) |-> $stable(pc1_o))
        else begin
            $error("pc1_o moved under stall_if");
            fail_cnt = fail_cnt + 1;
        end

    ////////////////////////////////////////////////////////////////////
    // Flush redirect and priority
    ////////////////////////////////////////////////////////////////////
    a_excp_target: assert property (@(posedge clk) disable iff (!arst_n_i)
        ctrl_i.excp_flush |=> pc1_o == $past(ctrl_pc_i))
        else begin
            $error("exception target not requested");
            fail_cnt = fail_cnt + 1;
        end

    a_br_target: assert property (@(posedge clk) disable iff (!arst_n_i)
        branch_flush_i && !ctrl_i.excp_flush |=> pc1_o == $past(branch_actual_addr_i))
        else begin
            $error("branch flush target not requested");
            fail_cnt = fail_cnt + 1;
        end

    a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
        branch_flush_i || ctrl_i.excp_flush |=> !inst_and_pc_o.valid_1)
        else begin
            $error("buffer not empty after flush");
            fail_cnt = fail_cnt + 1;
        end

endmodule

// File: tests/tb_frontend.sv
`include "frontend_macros.svh"

module tb_frontend
    import frontend_pkg::*;
();

    localparam int TOTAL_CYCLES = 698;
    localparam int MARGIN       = 200;
    localparam inst_t NO_DATA   = 32'hdead_beef;

    logic clk, arst_n;
    ctrl_t ctrl;
    ctrl_pc_t ctrl_pc;
    logic branch_flush, send1, send2;
    addr_t branch_addr, pc1, pc2, req_pc_q, exp_pc;
    addr_t req_pc2_q, br_tgt, excp_tgt;
    inst_t inst_1, inst_2;
    logic en_1, en_2, req_en_1_q, req_en_2_q;
    branch_info info1, info2;
    inst_and_pc_t pair;
    logic issue_stall, fetch_stall, pend_br, pend_excp;
    logic [31:0] rnd;
    integer seed, checks, errors, stall_cnt, phase_checks, phase_errors;

    frontend_top DUT (
        .clk(clk), .arst_n_i(arst_n), .ctrl_i(ctrl), .ctrl_pc_i(ctrl_pc),
        .branch_flush_i(branch_flush), .branch_actual_addr_i(branch_addr),
        .inst_1_i(inst_1), .inst_2_i(inst_2), .inst_en_1_o(en_1), .inst_en_2_o(en_2),
        .pc1_o(pc1), .pc2_o(pc2), .send_inst_1_en_i(send1), .send_inst_2_en_i(send2),
        .branch_info1_o(info1), .branch_info2_o(info2), .inst_and_pc_o(pair)
    );

    bind frontend_top frontend_assert u_assert (
        .clk(clk), .arst_n_i(arst_n_i), .ctrl_i(ctrl_i), .ctrl_pc_i(ctrl_pc_i),
        .branch_flush_i(branch_flush_i), .branch_actual_addr_i(branch_actual_addr_i),
        .inst_en_1_o(inst_en_1_o), .inst_en_2_o(inst_en_2_o), .pc1_o(pc1_o),
        .inst_and_pc_o(inst_and_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Program image: one branch per 256 bytes, backward when bit 8 is set
    function automatic inst_t prog_word(input addr_t a);
        if (a[7:4] == 4'ha && a[3:2] == 2'b01) begin
            return {`BR_OPCODE, 10'd0, a[8] ? 16'hfffa : 16'h0005};
        end
        return {6'h00, a[25:0]};
    endfunction

    function automatic integer error_total();
        return errors + DUT.u_assert.fail_cnt;
    endfunction

    task automatic check_entry(input addr_t pc, input inst_t inst, input branch_info bi);
        inst_t  w;
        addr_t  tgt;
        integer off;
        logic   is_br;
        logic   taken;
        w     = prog_word(pc);
        off   = signed'(w[15:0]);
        is_br = (w[31:26] == `BR_OPCODE);
        taken = is_br && (off < 0);
        tgt   = pc + addr_t'(off * 4);
        checks = checks + 1;
        assert (pc == exp_pc) else begin
            $display("[FAIL] pc got %h exp %h", pc, exp_pc);
            errors = errors + 1;
        end
        assert (inst == w) else begin
            $display("[FAIL] inst at %h got %h exp %h", pc, inst, w);
            errors = errors + 1;
        end
        assert (bi.is_branch == is_br && bi.pre_taken == taken
                && (!is_br || bi.pre_target == tgt)) else begin
            $display("[FAIL] branch_info at %h got %h exp %h", pc, bi, {is_br, taken, tgt});
            errors = errors + 1;
        end
        exp_pc = taken ? tgt : pc + 32'd4;
    endtask

    // One cycle: cache reply, issue stimulus, then checks
    task automatic step;
        logic a1;
        logic a2;
        @(negedge clk);
        // Cache answers last cycle's request, junk where nothing was asked
        inst_1 = req_en_1_q ? prog_word(req_pc_q) : NO_DATA;
        inst_2 = req_en_2_q ? prog_word(req_pc2_q) : NO_DATA;
        rnd = $random(seed);
        send1 = rnd[0];
        send2 = rnd[1];
        ctrl.stall_id = issue_stall | (rnd[4:2] == 3'd0);
        ctrl.stall_if = fetch_stall;
        ctrl.excp_flush = pend_excp;
        ctrl_pc = excp_tgt;
        branch_flush = pend_br;
        branch_addr = br_tgt;
        #1;
        req_pc_q = pc1;
        req_pc2_q = pc2;
        req_en_1_q = en_1;
        req_en_2_q = en_2;
        a1 = send1 & pair.valid_1 & ~ctrl.stall_id;
        a2 = a1 & send2 & pair.valid_2;
        if (a1) check_entry(pair.pc_1, pair.inst_1, info1);
        if (a2) check_entry(pair.pc_2, pair.inst_2, info2);
        if (pend_excp) exp_pc = ctrl_pc;
        else if (pend_br) exp_pc = branch_addr;
        stall_cnt = issue_stall ? stall_cnt + 1 : 0;
        if (stall_cnt > 20 || fetch_stall) begin
            checks = checks + 1;
            assert (!en_1) else begin
                $display("[FAIL] inst_en_1_o got %h exp 0 while fetch should hold", en_1);
                errors = errors + 1;
            end
        end
        pend_br = 1'b0;
        pend_excp = 1'b0;
    endtask

    task automatic run_cycles(input integer n);
        repeat (n) step();
    endtask

    task automatic flush_and_run(input logic br, input logic ex, input integer k);
        br_tgt = 32'h1c00_2000 + k * 32'h104;
        excp_tgt = 32'h1c00_8000 + k * 32'h0c4;
        pend_br = br;
        pend_excp = ex;
        run_cycles(30);
    endtask

    task automatic report_phase(input string name);
        $display("phase %-12s checks %0d errors %0d", name,
                 checks - phase_checks, error_total() - phase_errors);
        phase_checks = checks;
        phase_errors = error_total();
    endtask

    // Watchdog
    initial begin
        #((TOTAL_CYCLES + MARGIN) * 100);
        $display("Timeout: run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed = 56;
        checks = 0;
        errors = 0;
        stall_cnt = 0;
        phase_checks = 0;
        phase_errors = 0;
        arst_n = 1'b0;
        ctrl = '0;
        ctrl_pc = '0;
        branch_flush = 1'b0;
        branch_addr = '0;
        inst_1 = '0;
        inst_2 = '0;
        send1 = 1'b0;
        send2 = 1'b0;
        issue_stall = 1'b0;
        fetch_stall = 1'b0;
        pend_br = 1'b0;
        pend_excp = 1'b0;
        br_tgt = '0;
        excp_tgt = '0;
        req_pc_q = '0;
        req_pc2_q = '0;
        req_en_1_q = 1'b0;
        req_en_2_q = 1'b0;
        exp_pc = `RESET_PC;
        repeat (8) @(negedge clk);
        checks = checks + 1;
        assert (!en_1 && !pair.valid_1 && pc1 == `RESET_PC) else begin
            $display("[FAIL] reset state inst_en_1_o %h valid_1 %h pc1_o %h exp 0 0 %h",
                     en_1, pair.valid_1, pc1, `RESET_PC);
            errors = errors + 1;
        end
        arst_n = 1'b1;
        run_cycles(200);
        report_phase("free_run");
        issue_stall = 1'b1;
        run_cycles(40);
        issue_stall = 1'b0;
        run_cycles(60);
        report_phase("issue_stall");
        for (int k = 0; k < 4; k++) flush_and_run(1'b1, 1'b0, k);
        report_phase("branch_flush");
        for (int k = 0; k < 4; k++) flush_and_run(1'b0, 1'b1, k + 4);
        report_phase("excp_flush");
        for (int k = 0; k < 3; k++) flush_and_run(1'b1, 1'b1, k + 8);
        report_phase("both_flush");
        fetch_stall = 1'b1;
        run_cycles(20);
        fetch_stall = 1'b0;
        run_cycles(40);
        report_phase("fetch_stall");
        $display("Totals: checks %0d errors %0d", checks, error_total());
        if (error_total() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+logic
logic/frontend_pkg.sv
logic/pc_reg.sv
logic/bpu.sv
logic/instbuffer.sv
logic/frontend_top.sv
tests/frontend_assert.sv
tests/tb_frontend.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_frontend
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run ended without a result line"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
